// File: Makefile
# Verilator simulation of the two-channel CDC merger.
# Any variable below can be overridden on the make command line.

VERILATOR ?= verilator
TOP       ?= cdc_merge_tb
FILELIST  ?= cdc_merge_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cdc_merge_top.f
source/fifo_pkg.sv
source/merge_pkg.sv
source/dual_port_ram.sv
source/gray_ptr_sync.sv
source/async_fifo.sv
source/channel_merger.sv
source/cdc_merge_top.sv
verif/tb_clk_gen.sv
verif/cdc_merge_tb.sv

// File: source/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo
  import fifo_pkg::*;
(
  input  wire             wr_clk,
  input  wire             wr_rst_n,
  input  wire             wr_en,
  input  wire fifo_data_t wr_data,
  input  wire             rd_clk,
  input  wire             rd_rst_n,
  input  wire             rd_en,
  output fifo_data_t      rd_data,
  output logic            full,
  output logic            afull,
  output logic            empty
);

  logic      wr_vld;
  logic      rd_vld;

  fifo_ptr_t wr_bin;
  fifo_ptr_t wr_bin_nxt;
  fifo_ptr_t wr_gray;
  fifo_ptr_t wr_gray_nxt;

  fifo_ptr_t rd_bin;
  fifo_ptr_t rd_bin_nxt;
  fifo_ptr_t rd_gray;
  fifo_ptr_t rd_gray_nxt;

  fifo_ptr_t rd_gray_wsync;
  fifo_ptr_t rd_bin_wsync;
  fifo_ptr_t wr_gray_rsync;

  fifo_ptr_t full_match;
  fifo_ptr_t used_wr;

  assign wr_vld = wr_en && !full;   // writes while full are dropped.
  assign rd_vld = rd_en && !empty;

  dual_port_ram ram_i (
    .wr_clk   (wr_clk),
    .wr_en    (wr_vld),
    .wr_addr  (wr_bin[addr_width-1:0]),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_vld),
    .rd_addr  (rd_bin[addr_width-1:0]),
    .rd_data  (rd_data)
  );

  // read pointer into the write domain.
  gray_ptr_sync rd_to_wr_sync_i (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .gray_in  (rd_gray),
    .gray_out (rd_gray_wsync),
    .bin_out  (rd_bin_wsync)
  );

  // write pointer into the read domain. binary form has no user here.
  gray_ptr_sync wr_to_rd_sync_i (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .gray_in  (wr_gray),
    .gray_out (wr_gray_rsync),
    .bin_out  ()
  );

  assign wr_bin_nxt  = wr_bin + fifo_ptr_t'(wr_vld);
  assign wr_gray_nxt = wr_bin_nxt ^ (wr_bin_nxt >> 1);

  // full when write pointer is one lap ahead. top two gray bits differ.
  assign full_match = {~rd_gray_wsync[addr_width -: 2], rd_gray_wsync[addr_width-2:0]};
  assign used_wr    = wr_bin_nxt - rd_bin_wsync;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      full    <= 1'b0;
      afull   <= 1'b0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
      full    <= (wr_gray_nxt == full_match);
      afull   <= (used_wr >= fifo_ptr_t'(afull_level));
    end
  end

  assign rd_bin_nxt  = rd_bin + fifo_ptr_t'(rd_vld);
  assign rd_gray_nxt = rd_bin_nxt ^ (rd_bin_nxt >> 1);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
      empty   <= 1'b1;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
      empty   <= (rd_gray_nxt == wr_gray_rsync);  // same edge as the last pop.
    end
  end

endmodule

`default_nettype wire

// File: source/cdc_merge_top.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_merge_top
  import fifo_pkg::*;
  import merge_pkg::*;
(
  input  wire             rd_clk,
  input  wire             rd_rst_n,
  input  wire             drain_en,
  input  wire             wr_clk_a,
  input  wire             wr_rst_n_a,
  input  wire             wr_en_a,
  input  wire fifo_data_t wr_data_a,
  input  wire             wr_clk_b,
  input  wire             wr_rst_n_b,
  input  wire             wr_en_b,
  input  wire fifo_data_t wr_data_b,
  output logic            full_a,
  output logic            afull_a,
  output logic            full_b,
  output logic            afull_b,
  output logic            out_valid,
  output fifo_data_t      out_data,
  output chan_id_t        out_chan
);

  logic       rd_en_a;
  logic       rd_en_b;
  logic       empty_a;
  logic       empty_b;
  fifo_data_t rd_data_a;
  fifo_data_t rd_data_b;

  async_fifo fifo_a_i (
    .wr_clk   (wr_clk_a),
    .wr_rst_n (wr_rst_n_a),
    .wr_en    (wr_en_a),
    .wr_data  (wr_data_a),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en_a),
    .rd_data  (rd_data_a),
    .full     (full_a),
    .afull    (afull_a),
    .empty    (empty_a)
  );

  async_fifo fifo_b_i (
    .wr_clk   (wr_clk_b),
    .wr_rst_n (wr_rst_n_b),
    .wr_en    (wr_en_b),
    .wr_data  (wr_data_b),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en_b),
    .rd_data  (rd_data_b),
    .full     (full_b),
    .afull    (afull_b),
    .empty    (empty_b)
  );

  // both fifos drain into one tagged stream.
  channel_merger merger_i (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .drain_en  (drain_en),
    .empty_a   (empty_a),
    .empty_b   (empty_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .rd_en_a   (rd_en_a),
    .rd_en_b   (rd_en_b),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_chan  (out_chan)
  );

endmodule

`default_nettype wire

// File: source/channel_merger.sv
`timescale 1ns/1ps
`default_nettype none

module channel_merger
  import fifo_pkg::*;
  import merge_pkg::*;
(
  input  wire             rd_clk,
  input  wire             rd_rst_n,
  input  wire             drain_en,
  input  wire             empty_a,
  input  wire             empty_b,
  input  wire fifo_data_t rd_data_a,
  input  wire fifo_data_t rd_data_b,
  output logic            rd_en_a,
  output logic            rd_en_b,
  output logic            out_valid,
  output fifo_data_t      out_data,
  output chan_id_t        out_chan
);

  grant_state_t last_grant;

  logic         pick_a;
  logic         pick_b;

  logic         pop_vld;
  chan_id_t     pop_chan;

  // a wins when b is idle or b was served last.
  assign pick_a = drain_en && !empty_a && (empty_b || (last_grant == grant_b));
  assign pick_b = drain_en && !empty_b && !pick_a;

  assign rd_en_a = pick_a;
  assign rd_en_b = pick_b;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      last_grant <= grant_b;  // so a goes first.
      pop_vld    <= 1'b0;
      pop_chan   <= chan_a;
      out_valid  <= 1'b0;
    end else begin
      if (pick_a) begin
        last_grant <= grant_a;
      end else if (pick_b) begin
        last_grant <= grant_b;
      end
      pop_vld   <= pick_a || pick_b;
      pop_chan  <= pick_b ? chan_b : chan_a;
      out_valid <= pop_vld;
    end
  end

  // ram data lands one cycle after the pop.
  always_ff @(posedge rd_clk) begin
    if (pop_vld) begin
      out_data <= (pop_chan == chan_b) ? rd_data_b : rd_data_a;
      out_chan <= pop_chan;
    end
  end

endmodule

`default_nettype wire

// File: source/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram
  import fifo_pkg::*;
(
  input  wire             wr_clk,
  input  wire             wr_en,
  input  wire fifo_addr_t wr_addr,
  input  wire fifo_data_t wr_data,
  input  wire             rd_clk,
  input  wire             rd_rst_n,
  input  wire             rd_en,
  input  wire fifo_addr_t rd_addr,
  output fifo_data_t      rd_data
);

  fifo_data_t mem [fifo_depth];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read word is valid the cycle after rd_en.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: source/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

  // word and storage geometry.
  localparam int data_width  = 8;
  localparam int fifo_depth  = 16;
  localparam int addr_width  = $clog2(fifo_depth);

  // used count at which afull is raised.
  localparam int afull_level = fifo_depth - 1;

  typedef logic [data_width-1:0] fifo_data_t;
  typedef logic [addr_width-1:0] fifo_addr_t;

  // address plus wrap bit, binary or gray form.
  typedef logic [addr_width:0]   fifo_ptr_t;

endpackage

`default_nettype wire

// File: source/gray_ptr_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_sync
  import fifo_pkg::*;
(
  input  wire            clk,
  input  wire            rst_n,
  input  wire fifo_ptr_t gray_in,
  output fifo_ptr_t      gray_out,
  output fifo_ptr_t      bin_out
);

  fifo_ptr_t sync_q1;
  fifo_ptr_t sync_q2;

  // gray_in comes from the other clock domain.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;
      sync_q2 <= sync_q1;
    end
  end

  assign gray_out = sync_q2;

  // each binary bit is the xor of all gray bits at or above it.
  always_comb begin
    for (int i = 0; i <= addr_width; i++) begin
      bin_out[i] = ^(sync_q2 >> i);
    end
  end

endmodule

`default_nettype wire

// File: source/merge_pkg.sv
`default_nettype none

package merge_pkg;

  // source channel of a merged word.
  typedef logic [0:0] chan_id_t;

  localparam chan_id_t chan_a = 1'b0;
  localparam chan_id_t chan_b = 1'b1;

  // last channel served by the round robin.
  typedef enum logic {
    grant_a = 1'b0,
    grant_b = 1'b1
  } grant_state_t;

endpackage

`default_nettype wire

// File: verif/cdc_merge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_merge_tb
  import fifo_pkg::*;
  import merge_pkg::*;
();

  logic       rd_clk;
  logic       wr_clk_a;
  logic       wr_clk_b;
  logic       rd_rst_n;
  logic       wr_rst_n_a;
  logic       wr_rst_n_b;
  logic       drain_en;
  logic       wr_en_a;
  logic       wr_en_b;
  fifo_data_t wr_data_a;
  fifo_data_t wr_data_b;
  logic       full_a;
  logic       afull_a;
  logic       full_b;
  logic       afull_b;
  logic       out_valid;
  fifo_data_t out_data;
  chan_id_t   out_chan;

  fifo_data_t exp_a[$];   // accepted words of channel a, oldest first.
  fifo_data_t exp_b[$];
  chan_id_t   chan_log[$];
  int         out_count = 0;
  integer     seed;

  tb_clk_gen #(.period(100.0)) rd_clk_gen_i (.clk(rd_clk));
  tb_clk_gen #(.period(70.0))  wr_clk_a_gen_i (.clk(wr_clk_a));
  tb_clk_gen #(.period(130.0)) wr_clk_b_gen_i (.clk(wr_clk_b));

  cdc_merge_top dut_i (
    .rd_clk     (rd_clk),
    .rd_rst_n   (rd_rst_n),
    .drain_en   (drain_en),
    .wr_clk_a   (wr_clk_a),
    .wr_rst_n_a (wr_rst_n_a),
    .wr_en_a    (wr_en_a),
    .wr_data_a  (wr_data_a),
    .wr_clk_b   (wr_clk_b),
    .wr_rst_n_b (wr_rst_n_b),
    .wr_en_b    (wr_en_b),
    .wr_data_b  (wr_data_b),
    .full_a     (full_a),
    .afull_a    (afull_a),
    .full_b     (full_b),
    .afull_b    (afull_b),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_chan   (out_chan)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input fifo_data_t got, input fifo_data_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_chan(input string name, input chan_id_t got, input chan_id_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_count(input int start, input int n);
    if (out_count - start != n) begin
      stop_on_error($sformatf("expected %0d output words but saw %0d", n, out_count - start));
    end
  endtask

  // a write is accepted when full is low at the next rising edge.
  task automatic write_word(input chan_id_t chan, input fifo_data_t data);
    if (chan == chan_a) begin
      @(negedge wr_clk_a);
      wr_en_a   = 1'b1;
      wr_data_a = data;
      if (!full_a) begin
        exp_a.push_back(data);
      end
    end else begin
      @(negedge wr_clk_b);
      wr_en_b   = 1'b1;
      wr_data_b = data;
      if (!full_b) begin
        exp_b.push_back(data);
      end
    end
  endtask

  task automatic stop_write(input chan_id_t chan);
    if (chan == chan_a) begin
      @(negedge wr_clk_a);
      wr_en_a = 1'b0;
    end else begin
      @(negedge wr_clk_b);
      wr_en_b = 1'b0;
    end
  endtask

  task automatic set_drain(input logic level);
    @(negedge rd_clk);
    drain_en = level;
  endtask

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    while (exp_a.size() != 0 || exp_b.size() != 0) begin
      if (n >= max_cycles) begin
        stop_on_error("timed out waiting for the written words to reach the output");
      end else begin
        @(negedge rd_clk);
        n++;
      end
    end
    repeat (4) @(negedge rd_clk);  // let pointers settle across domains.
  endtask

  // outputs are registered on rd_clk, sampled here as a flop would.
  always @(posedge rd_clk) begin
    if (rd_rst_n && out_valid) begin
      chan_log.push_back(out_chan);
      out_count++;
      if (out_chan == chan_a) begin
        if (exp_a.size() == 0) begin
          stop_on_error("channel a produced a word that was never accepted");
        end else begin
          check_data("out_data", out_data, exp_a.pop_front());
        end
      end else begin
        if (exp_b.size() == 0) begin
          stop_on_error("channel b produced a word that was never accepted");
        end else begin
          check_data("out_data", out_data, exp_b.pop_front());
        end
      end
    end
  end

  task automatic test_reset_state();
    @(negedge rd_clk);
    check_flag("full_a", full_a, 1'b0);
    check_flag("afull_a", afull_a, 1'b0);
    check_flag("full_b", full_b, 1'b0);
    check_flag("afull_b", afull_b, 1'b0);
    set_drain(1'b1);   // empty fifos must not pop.
    repeat (20) begin
      @(negedge rd_clk);
      check_flag("out_valid", out_valid, 1'b0);
    end
  endtask

  task automatic test_single_word();
    int start;
    start = out_count;
    set_drain(1'b1);
    write_word(chan_a, fifo_data_t'($random(seed)));
    stop_write(chan_a);
    write_word(chan_b, fifo_data_t'($random(seed)));
    stop_write(chan_b);
    wait_drained(50);
    check_count(start, 2);
  endtask

  task automatic test_fill_overflow();
    int start;
    int i;
    start = out_count;
    set_drain(1'b0);
    for (i = 0; i < 15; i++) begin
      write_word(chan_a, fifo_data_t'($random(seed)));
    end
    check_flag("afull_a", afull_a, 1'b0);   // fourteen words in.
    write_word(chan_a, fifo_data_t'($random(seed)));
    check_flag("afull_a", afull_a, 1'b1);
    check_flag("full_a", full_a, 1'b0);
    write_word(chan_a, fifo_data_t'($random(seed)));   // seventeenth, dropped.
    check_flag("full_a", full_a, 1'b1);
    stop_write(chan_a);
    set_drain(1'b1);
    wait_drained(100);
    check_count(start, 16);
  endtask

  task automatic test_fairness();
    int first;
    int i;
    // serve b once so a leads the next round.
    write_word(chan_b, fifo_data_t'($random(seed)));
    stop_write(chan_b);
    wait_drained(50);
    set_drain(1'b0);
    for (i = 0; i < 6; i++) begin
      write_word(chan_a, fifo_data_t'($random(seed)));
    end
    stop_write(chan_a);
    for (i = 0; i < 6; i++) begin
      write_word(chan_b, fifo_data_t'($random(seed)));
    end
    stop_write(chan_b);
    repeat (6) @(negedge rd_clk);
    first = chan_log.size();
    set_drain(1'b1);
    wait_drained(100);
    if (chan_log.size() - first != 12) begin
      stop_on_error("fairness drain did not produce twelve words");
    end
    for (i = 0; i < 12; i++) begin
      check_chan("out_chan", chan_log[first + i], (i % 2 == 0) ? chan_a : chan_b);
    end
  endtask

  task automatic random_writes(input chan_id_t chan, input int n);
    int i;
    for (i = 0; i < n; i++) begin
      write_word(chan, fifo_data_t'($random(seed)));
      if (($random(seed) & 3) == 0) begin
        stop_write(chan);   // idle gap.
      end
    end
    stop_write(chan);
  endtask

  task automatic test_random_traffic();
    set_drain(1'b1);
    fork
      random_writes(chan_a, 200);
      random_writes(chan_b, 200);
    join
    wait_drained(200);
  endtask

  initial begin
    seed       = 32'ha3c10586;
    rd_rst_n   = 1'b0;
    wr_rst_n_a = 1'b0;
    wr_rst_n_b = 1'b0;
    drain_en   = 1'b0;
    wr_en_a    = 1'b0;
    wr_en_b    = 1'b0;
    wr_data_a  = '0;
    wr_data_b  = '0;
    fork
      begin
        repeat (2) @(negedge rd_clk);
        rd_rst_n = 1'b1;
      end
      begin
        repeat (2) @(negedge wr_clk_a);
        wr_rst_n_a = 1'b1;
      end
      begin
        repeat (2) @(negedge wr_clk_b);
        wr_rst_n_b = 1'b1;
      end
    join
    test_reset_state();
    test_single_word();
    test_fill_overflow();
    test_fairness();
    test_random_traffic();
    if (exp_a.size() == 0 && exp_b.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      stop_on_error("accepted words were still undelivered at the end of the run");
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real period = 100.0
) (
  output logic clk
);

  // starts low, first rising edge at half a period.
  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2.0);
      clk = ~clk;
    end
  end

endmodule

`default_nettype wire
